//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tbMipsExec
FILELIST  = sim.f
BUILD_DIR = obj_dir
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/aluLane.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one MIPS execution lane.
// decode, operand select, ALU,
// overflow trap, output register.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aluLane (
    input  logic        clk,
    input  logic        rstN,
    laneIf.lane         issue,
    output logic        resValid,
    output logic [31:0] resData,
    output logic        resTrap
);

    mipsExecPkg::rType_s rType;
    mipsExecPkg::iType_s iType;
    logic                isRType;
    logic                signExt;
    logic                shiftImm;
    logic [3:0]          aluOp;
    logic [31:0]         extImm;
    logic [31:0]         srcA;
    logic [31:0]         srcB;
    logic [31:0]         aluOut;
    logic                trapAdd;
    logic                trapSub;
    logic                trap;

    function automatic logic [31:0] aluCalc(input logic [31:0] a, input logic [31:0] b,
                                            input logic [3:0] op);
        case (op)
            mipsExecPkg::ALU_A:    return a;
            mipsExecPkg::ALU_B:    return b;
            mipsExecPkg::ALU_ADD:  return a + b;
            mipsExecPkg::ALU_SUB:  return a - b;
            mipsExecPkg::ALU_AND:  return a & b;
            mipsExecPkg::ALU_OR:   return a | b;
            mipsExecPkg::ALU_XOR:  return a ^ b;
            mipsExecPkg::ALU_NOR:  return ~(a | b);
            mipsExecPkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            mipsExecPkg::ALU_SLTU: return {31'b0, a < b};
            mipsExecPkg::ALU_SLL:  return b << a[4:0];
            mipsExecPkg::ALU_SRL:  return b >> a[4:0];
            mipsExecPkg::ALU_SRA:  return $signed(b) >>> a[4:0];
            mipsExecPkg::ALU_LUI:  return {b[15:0], 16'b0};
            default:               return '0;
        endcase
    endfunction

    assign rType   = issue.instr.rType;
    assign iType   = issue.instr.iType;
    assign isRType = (rType.opcode == mipsExecPkg::OP_SPECIAL);

    always_comb
    begin
        aluOp = mipsExecPkg::ALU_ZERO; // unknown encodings yield zero.
        if (isRType)
        begin
            case (rType.funct)
                mipsExecPkg::FN_ADD, mipsExecPkg::FN_ADDU:  aluOp = mipsExecPkg::ALU_ADD;
                mipsExecPkg::FN_SUB, mipsExecPkg::FN_SUBU:  aluOp = mipsExecPkg::ALU_SUB;
                mipsExecPkg::FN_AND:                        aluOp = mipsExecPkg::ALU_AND;
                mipsExecPkg::FN_OR:                         aluOp = mipsExecPkg::ALU_OR;
                mipsExecPkg::FN_XOR:                        aluOp = mipsExecPkg::ALU_XOR;
                mipsExecPkg::FN_NOR:                        aluOp = mipsExecPkg::ALU_NOR;
                mipsExecPkg::FN_SLT:                        aluOp = mipsExecPkg::ALU_SLT;
                mipsExecPkg::FN_SLTU:                       aluOp = mipsExecPkg::ALU_SLTU;
                mipsExecPkg::FN_SLL, mipsExecPkg::FN_SLLV:  aluOp = mipsExecPkg::ALU_SLL;
                mipsExecPkg::FN_SRL, mipsExecPkg::FN_SRLV:  aluOp = mipsExecPkg::ALU_SRL;
                mipsExecPkg::FN_SRA, mipsExecPkg::FN_SRAV:  aluOp = mipsExecPkg::ALU_SRA;
                default:                                    aluOp = mipsExecPkg::ALU_ZERO;
            endcase
        end
        else
        begin
            case (iType.opcode)
                mipsExecPkg::OP_ADDI, mipsExecPkg::OP_ADDIU: aluOp = mipsExecPkg::ALU_ADD;
                mipsExecPkg::OP_SLTI:                        aluOp = mipsExecPkg::ALU_SLT;
                mipsExecPkg::OP_SLTIU:                       aluOp = mipsExecPkg::ALU_SLTU;
                mipsExecPkg::OP_ANDI:                        aluOp = mipsExecPkg::ALU_AND;
                mipsExecPkg::OP_ORI:                         aluOp = mipsExecPkg::ALU_OR;
                mipsExecPkg::OP_XORI:                        aluOp = mipsExecPkg::ALU_XOR;
                mipsExecPkg::OP_LUI:                         aluOp = mipsExecPkg::ALU_LUI;
                default:                                     aluOp = mipsExecPkg::ALU_ZERO;
            endcase
        end
    end

    // logical immediates and LUI take zero extension.
    assign signExt = !(iType.opcode inside {mipsExecPkg::OP_ANDI, mipsExecPkg::OP_ORI,
                                            mipsExecPkg::OP_XORI, mipsExecPkg::OP_LUI});
    assign extImm  = signExt ? {{16{iType.imm16[15]}}, iType.imm16} : {16'b0, iType.imm16};

    assign shiftImm = isRType && (rType.funct inside {mipsExecPkg::FN_SLL, mipsExecPkg::FN_SRL,
                                                      mipsExecPkg::FN_SRA});
    assign srcA   = shiftImm ? {27'b0, rType.shamt} : issue.dataRs;
    assign srcB   = isRType ? issue.dataRt : extImm;
    assign aluOut = aluCalc(srcA, srcB, aluOp);

    assign trapAdd = (isRType && rType.funct == mipsExecPkg::FN_ADD)
                     || iType.opcode == mipsExecPkg::OP_ADDI;
    assign trapSub = isRType && rType.funct == mipsExecPkg::FN_SUB;
    assign trap    = (trapAdd && srcA[31] == srcB[31] && aluOut[31] != srcA[31])
                     || (trapSub && srcA[31] != srcB[31] && aluOut[31] != srcA[31]);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            resValid <= 1'b0;
            resTrap  <= 1'b0;
        end
        else
        begin
            resValid <= issue.valid;
            resTrap  <= trap;
        end
    end

    always_ff @(posedge clk)
    begin
        resData <= aluOut;
    end

endmodule

//--- rtl/apbRegs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave for the lanes.
// operand storage, launch pulse,
// read mux and pslverr.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module apbRegs (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [mipsExecPkg::APB_ADDR_W-1:0]  paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    laneIf.feeder                               issue [mipsExecPkg::NUM_LANES],
    output logic [mipsExecPkg::NUM_LANES-1:0]   clearDone,
    input  logic [mipsExecPkg::NUM_LANES-1:0][31:0] resultBank,
    input  logic [mipsExecPkg::NUM_LANES-1:0]   doneBits,
    input  logic [mipsExecPkg::NUM_LANES-1:0]   trapBits
);

    logic                                 access;
    logic                                 inWindow;
    logic                                 isStatus;
    logic [mipsExecPkg::LANE_IDX_W-1:0]   laneSel;
    logic [3:0]                           regOff;
    logic                                 errCond;
    logic [31:0]                          rdMux;
    logic                                 wrOk;
    logic                                 wrInstr;
    logic                                 rdResultOk;
    logic [31:0]                          rsReg [mipsExecPkg::NUM_LANES];
    logic [31:0]                          rtReg [mipsExecPkg::NUM_LANES];

    assign access   = psel && penable;
    assign inWindow = (paddr[mipsExecPkg::APB_ADDR_W-1:6] == '0);
    assign isStatus = (paddr == mipsExecPkg::REG_STATUS);
    assign laneSel  = paddr[5:4];
    assign regOff   = paddr[3:0];
    assign pready   = 1'b1; // no wait states.

    always_comb
    begin
        errCond = 1'b1; // unmapped unless matched below.
        if (isStatus)
            errCond = pwrite;
        else if (inWindow)
        begin
            case (regOff)
                mipsExecPkg::REG_RS,
                mipsExecPkg::REG_RT,
                mipsExecPkg::REG_INSTR:  errCond = 1'b0;
                mipsExecPkg::REG_RESULT: errCond = pwrite || !doneBits[laneSel];
                default:                 errCond = 1'b1;
            endcase
        end
    end

    always_comb
    begin
        rdMux = '0; // write-only registers read as zero.
        if (isStatus)
            rdMux = 32'({trapBits, doneBits});
        else if (inWindow && regOff == mipsExecPkg::REG_RESULT)
            rdMux = resultBank[laneSel];
    end

    assign prdata  = (access && !pwrite && !errCond) ? rdMux : '0;
    assign pslverr = access && errCond;

    assign wrOk       = access && pwrite && !errCond;
    assign wrInstr    = wrOk && inWindow && regOff == mipsExecPkg::REG_INSTR;
    assign rdResultOk = access && !pwrite && !errCond && inWindow
                        && regOff == mipsExecPkg::REG_RESULT;
    assign clearDone  = rdResultOk ? (mipsExecPkg::NUM_LANES'(1) << laneSel) : '0;

    always_ff @(posedge clk)
    begin
        if (wrOk && inWindow && regOff == mipsExecPkg::REG_RS)
            rsReg[laneSel] <= pwdata;
        if (wrOk && inWindow && regOff == mipsExecPkg::REG_RT)
            rtReg[laneSel] <= pwdata;
    end

    for (genvar g = 0; g < mipsExecPkg::NUM_LANES; g++)
    begin : gIssue
        always_ff @(posedge clk or negedge rstN)
        begin
            if (!rstN)
                issue[g].valid <= 1'b0;
            else
                issue[g].valid <= wrInstr && (laneSel == mipsExecPkg::LANE_IDX_W'(g));
        end

        // operands travel with the launch pulse.
        always_ff @(posedge clk)
        begin
            if (wrInstr && laneSel == mipsExecPkg::LANE_IDX_W'(g))
            begin
                issue[g].instr  <= pwdata;
                issue[g].dataRs <= rsReg[g];
                issue[g].dataRt <= rtReg[g];
            end
        end
    end

endmodule

//--- rtl/laneIf.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue path from the APB
// feeder into one ALU lane.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface laneIf;

    logic                   valid; // one-cycle launch pulse.
    mipsExecPkg::instrWord_u instr;
    logic [31:0]            dataRs;
    logic [31:0]            dataRt;

    modport feeder (
        output valid, instr, dataRs, dataRt
    );

    modport lane (
        input valid, instr, dataRs, dataRt
    );

endinterface

//--- rtl/mipsExecPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants for the MIPS execution accelerator.
// lane count, APB register map, opcodes, funct codes,
// ALU operation codes and the instruction word union.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsExecPkg;

    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;
    localparam int APB_ADDR_W = 8;

    // offsets inside a 16-byte lane window.
    localparam logic [3:0] REG_RS     = 4'h0;
    localparam logic [3:0] REG_RT     = 4'h4;
    localparam logic [3:0] REG_INSTR  = 4'h8; // write launches.
    localparam logic [3:0] REG_RESULT = 4'hC; // read clears done.

    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h40;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_SLTIU   = 6'h0B;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    localparam logic [3:0] ALU_ZERO = 4'd0;
    localparam logic [3:0] ALU_A    = 4'd1;
    localparam logic [3:0] ALU_B    = 4'd2;
    localparam logic [3:0] ALU_ADD  = 4'd3;
    localparam logic [3:0] ALU_SUB  = 4'd4;
    localparam logic [3:0] ALU_AND  = 4'd5;
    localparam logic [3:0] ALU_OR   = 4'd6;
    localparam logic [3:0] ALU_XOR  = 4'd7;
    localparam logic [3:0] ALU_NOR  = 4'd8;
    localparam logic [3:0] ALU_SLT  = 4'd9;
    localparam logic [3:0] ALU_SLTU = 4'd10;
    localparam logic [3:0] ALU_SLL  = 4'd11;
    localparam logic [3:0] ALU_SRL  = 4'd12;
    localparam logic [3:0] ALU_SRA  = 4'd13;
    localparam logic [3:0] ALU_LUI  = 4'd14;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_s;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iType_s;

    // one word, two decodings.
    typedef union packed {
        rType_s rType;
        iType_s iType;
    } instrWord_u;

endpackage

//--- rtl/mipsExecTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the accelerator.
// APB feeder, lane array, collector.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mipsExecTop (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [mipsExecPkg::APB_ADDR_W-1:0] paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr
);

    logic [mipsExecPkg::NUM_LANES-1:0]       resValid;
    logic [mipsExecPkg::NUM_LANES-1:0]       resTrap;
    logic [mipsExecPkg::NUM_LANES-1:0][31:0] resData;
    logic [mipsExecPkg::NUM_LANES-1:0]       clearDone;
    logic [mipsExecPkg::NUM_LANES-1:0][31:0] resultBank;
    logic [mipsExecPkg::NUM_LANES-1:0]       doneBits;
    logic [mipsExecPkg::NUM_LANES-1:0]       trapBits;

    laneIf issue [mipsExecPkg::NUM_LANES] ();

    apbRegs apbRegs_i (
        .clk        (clk),
        .rstN       (rstN),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .issue      (issue),
        .clearDone  (clearDone),
        .resultBank (resultBank),
        .doneBits   (doneBits),
        .trapBits   (trapBits)
    );

    for (genvar g = 0; g < mipsExecPkg::NUM_LANES; g++)
    begin : gLane
        aluLane aluLane_i (
            .clk      (clk),
            .rstN     (rstN),
            .issue    (issue[g]),
            .resValid (resValid[g]),
            .resData  (resData[g]),
            .resTrap  (resTrap[g])
        );
    end

    resultCollector resultCollector_i (
        .clk        (clk),
        .rstN       (rstN),
        .resValid   (resValid),
        .resTrap    (resTrap),
        .resData    (resData),
        .clearDone  (clearDone),
        .resultBank (resultBank),
        .doneBits   (doneBits),
        .trapBits   (trapBits)
    );

endmodule

//--- rtl/resultCollector.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-lane result, done and trap
// registers read back over APB.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module resultCollector (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic [mipsExecPkg::NUM_LANES-1:0]       resValid,
    input  logic [mipsExecPkg::NUM_LANES-1:0]       resTrap,
    input  logic [mipsExecPkg::NUM_LANES-1:0][31:0] resData,
    input  logic [mipsExecPkg::NUM_LANES-1:0]       clearDone,
    output logic [mipsExecPkg::NUM_LANES-1:0][31:0] resultBank,
    output logic [mipsExecPkg::NUM_LANES-1:0]       doneBits,
    output logic [mipsExecPkg::NUM_LANES-1:0]       trapBits
);

    for (genvar g = 0; g < mipsExecPkg::NUM_LANES; g++)
    begin : gSlot
        always_ff @(posedge clk or negedge rstN)
        begin
            if (!rstN)
            begin
                doneBits[g] <= 1'b0;
                trapBits[g] <= 1'b0;
            end
            else if (resValid[g]) // a fresh result beats the clear.
            begin
                doneBits[g] <= 1'b1;
                trapBits[g] <= resTrap[g];
            end
            else if (clearDone[g])
                doneBits[g] <= 1'b0;
        end

        always_ff @(posedge clk)
        begin
            if (resValid[g])
                resultBank[g] <= resData[g];
        end
    end

endmodule

//--- sim.f
rtl/mipsExecPkg.sv
rtl/laneIf.sv
rtl/apbRegs.sv
rtl/aluLane.sv
rtl/resultCollector.sv
rtl/mipsExecTop.sv
verif/clkRstGen.sv
verif/mipsExec_props.sv
verif/tbMipsExec.sv

//--- verif/clkRstGen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset.
// 4 ns clock, reset low for 4 cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module clkRstGen (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk; // half period.
    end

    initial
    begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1; // release away from the edge.
    end

endmodule

//--- verif/mipsExec_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB and launch properties,
// bound into the top level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mipsExecProps (
    input logic                               clk,
    input logic                               rstN,
    input logic                               psel,
    input logic                               penable,
    input logic                               pwrite,
    input logic [mipsExecPkg::APB_ADDR_W-1:0] paddr,
    input logic [31:0]                        prdata,
    input logic                               pready,
    input logic                               pslverr,
    input logic [mipsExecPkg::NUM_LANES-1:0]  doneBits
);
    timeunit 1ns;
    timeprecision 100ps;

    int   errCount = 0;
    logic instrWrite;

    // accepted write to some lane's INSTR register.
    assign instrWrite = psel && penable && pwrite && !pslverr
                        && paddr[mipsExecPkg::APB_ADDR_W-1:6] == '0
                        && paddr[3:0] == mipsExecPkg::REG_INSTR;

    readyHigh: assert property (@(posedge clk) disable iff (!rstN) pready)
    else
    begin
        errCount++;
        $error("pready dropped low out of reset");
    end

    errInAccess: assert property (@(posedge clk) disable iff (!rstN)
        pslverr |-> psel && penable)
    else
    begin
        errCount++;
        $error("pslverr high outside an access phase");
    end

    idleData: assert property (@(posedge clk) disable iff (!rstN)
        !psel |-> prdata == '0)
    else
    begin
        errCount++;
        $error("prdata not zero while psel is low");
    end

    for (genvar g = 0; g < mipsExecPkg::NUM_LANES; g++)
    begin : gDone
        // launch at T, done visible at T+3.
        doneAfterLaunch: assert property (@(posedge clk) disable iff (!rstN)
            instrWrite && paddr[5:4] == mipsExecPkg::LANE_IDX_W'(g) |-> ##3 doneBits[g])
        else
        begin
            errCount++;
            $error("lane done bit not set three cycles after launch");
        end
    end

endmodule

bind mipsExecTop mipsExecProps mipsExecProps_i (
    .clk      (clk),
    .rstN     (rstN),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .doneBits (doneBits)
);

//--- verif/tbMipsExec.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the accelerator.
// APB tasks, reference ALU model,
// directed and random tests, watchdog.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbMipsExec;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_RUNS       = 300;
    localparam int CYCLES_PER_RUN = 21; // about seven transfers of three cycles.
    localparam int TIMEOUT_CYCLES = 2 * NUM_RUNS * CYCLES_PER_RUN;

    logic                               clk;
    logic                               rstN;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [mipsExecPkg::APB_ADDR_W-1:0] paddr;
    logic [31:0]                        pwdata;
    logic [31:0]                        prdata;
    logic                               pready;
    logic                               pslverr;

    logic [5:0] rFuncts[$] = '{mipsExecPkg::FN_ADD, mipsExecPkg::FN_ADDU, mipsExecPkg::FN_SUB,
                               mipsExecPkg::FN_SUBU, mipsExecPkg::FN_AND, mipsExecPkg::FN_OR,
                               mipsExecPkg::FN_XOR, mipsExecPkg::FN_NOR, mipsExecPkg::FN_SLT,
                               mipsExecPkg::FN_SLTU, mipsExecPkg::FN_SLLV, mipsExecPkg::FN_SRLV,
                               mipsExecPkg::FN_SRAV};
    logic [5:0] iOps[$] = '{mipsExecPkg::OP_ADDI, mipsExecPkg::OP_ADDIU, mipsExecPkg::OP_SLTI,
                            mipsExecPkg::OP_SLTIU, mipsExecPkg::OP_ANDI, mipsExecPkg::OP_ORI,
                            mipsExecPkg::OP_XORI, mipsExecPkg::OP_LUI};
    logic [5:0] sFuncts[$] = '{mipsExecPkg::FN_SLL, mipsExecPkg::FN_SRL, mipsExecPkg::FN_SRA};

    clkRstGen clkRstGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    mipsExecTop mipsExecTop_i (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        assert (actVal === expVal)
        else
        begin
            $display("Fail %s: expected %h, actual %h", name, expVal, actVal);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic logic [mipsExecPkg::APB_ADDR_W-1:0] laneAddr(input int lane,
                                                                    input logic [3:0] off);
        return {2'b00, 2'(lane), off};
    endfunction

    // one APB transfer with the response sampled late in the access phase.
    task automatic apbXfer(input logic write, input logic [mipsExecPkg::APB_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeOk(input logic [mipsExecPkg::APB_ADDR_W-1:0] addr,
                           input logic [31:0] data, input string name);
        logic [31:0] unused;
        logic        err;
        apbXfer(1'b1, addr, data, unused, err);
        checkVal({name, " write pslverr"}, 32'h0, {31'b0, err});
    endtask

    task automatic readOk(input logic [mipsExecPkg::APB_ADDR_W-1:0] addr, input string name,
                          output logic [31:0] data);
        logic err;
        apbXfer(1'b0, addr, 32'h0, data, err);
        checkVal({name, " read pslverr"}, 32'h0, {31'b0, err});
    endtask

    // MIPS semantics straight from the instruction set with a trap on signed overflow.
    function automatic logic [31:0] refResult(input logic [31:0] instr, input logic [31:0] a,
                                              input logic [31:0] b, output logic trap);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [32:0] wide;
        logic [31:0] res;
        op   = instr[31:26];
        fn   = instr[5:0];
        sh   = instr[10:6];
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'h0, instr[15:0]};
        res  = '0;
        wide = '0;
        trap = 1'b0;
        if (op == mipsExecPkg::OP_SPECIAL)
        begin
            case (fn)
                mipsExecPkg::FN_ADD, mipsExecPkg::FN_ADDU:
                begin
                    wide = {a[31], a} + {b[31], b};
                    res  = wide[31:0];
                    trap = (fn == mipsExecPkg::FN_ADD) && (wide[32] != wide[31]);
                end
                mipsExecPkg::FN_SUB, mipsExecPkg::FN_SUBU:
                begin
                    wide = {a[31], a} - {b[31], b};
                    res  = wide[31:0];
                    trap = (fn == mipsExecPkg::FN_SUB) && (wide[32] != wide[31]);
                end
                mipsExecPkg::FN_AND:  res = a & b;
                mipsExecPkg::FN_OR:   res = a | b;
                mipsExecPkg::FN_XOR:  res = a ^ b;
                mipsExecPkg::FN_NOR:  res = ~(a | b);
                mipsExecPkg::FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                mipsExecPkg::FN_SLTU: res = {31'b0, a < b};
                mipsExecPkg::FN_SLL:  res = b << sh;
                mipsExecPkg::FN_SRL:  res = b >> sh;
                mipsExecPkg::FN_SRA:  res = $signed(b) >>> sh;
                mipsExecPkg::FN_SLLV: res = b << a[4:0];
                mipsExecPkg::FN_SRLV: res = b >> a[4:0];
                mipsExecPkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                default:              res = '0;
            endcase
        end
        else
        begin
            case (op)
                mipsExecPkg::OP_ADDI, mipsExecPkg::OP_ADDIU:
                begin
                    wide = {a[31], a} + {sImm[31], sImm};
                    res  = wide[31:0];
                    trap = (op == mipsExecPkg::OP_ADDI) && (wide[32] != wide[31]);
                end
                mipsExecPkg::OP_SLTI:  res = {31'b0, $signed(a) < $signed(sImm)};
                mipsExecPkg::OP_SLTIU: res = {31'b0, a < sImm};
                mipsExecPkg::OP_ANDI:  res = a & zImm;
                mipsExecPkg::OP_ORI:   res = a | zImm;
                mipsExecPkg::OP_XORI:  res = a ^ zImm;
                mipsExecPkg::OP_LUI:   res = {instr[15:0], 16'h0};
                default:               res = '0;
            endcase
        end
        return res;
    endfunction

    task automatic waitDone(input int lane, input string name);
        logic [31:0] status;
        do
            readOk(mipsExecPkg::REG_STATUS, {name, " poll"}, status);
        while (((status >> lane) & 32'h1) == 32'h0);
    endtask

    // load operands, launch, wait, then check result, done clear and trap.
    task automatic runOne(input int lane, input logic [31:0] instr, input logic [31:0] a,
                          input logic [31:0] b, input string name);
        logic [31:0] expRes;
        logic        expTrap;
        logic [31:0] got;
        logic [31:0] status;
        expRes = refResult(instr, a, b, expTrap);
        writeOk(laneAddr(lane, mipsExecPkg::REG_RS), a, name);
        writeOk(laneAddr(lane, mipsExecPkg::REG_RT), b, name);
        writeOk(laneAddr(lane, mipsExecPkg::REG_INSTR), instr, name);
        waitDone(lane, name);
        readOk(laneAddr(lane, mipsExecPkg::REG_RESULT), name, got);
        checkVal({name, " result"}, expRes, got);
        readOk(mipsExecPkg::REG_STATUS, name, status);
        checkVal({name, " done cleared"}, 32'h0, (status >> lane) & 32'h1);
        checkVal({name, " trap"}, {31'b0, expTrap},
                 (status >> (lane + mipsExecPkg::NUM_LANES)) & 32'h1);
    endtask

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    // stop at the first failed property.
    initial
    begin
        wait (mipsExecTop_i.mipsExecProps_i.errCount != 0);
        $display("A property check failed at %0t ns", $time);
        $display("Errors found");
        $fatal(1);
    end

    initial
    begin
        logic [31:0] data;
        logic        err;
        logic [31:0] instr;
        logic [5:0]  fn;
        logic [15:0] imm;
        int          idx;
        logic [31:0] aOps[$];
        logic [31:0] bOps[$];
        logic [31:0] instrs[$];
        logic        trapDummy;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h499dab9f));
        wait (rstN === 1'b1);

        readOk(mipsExecPkg::REG_STATUS, "status after reset", data);
        checkVal("status after reset", 32'h0, data);

        for (int i = 0; i < 200; i++)
        begin
            idx   = int'($urandom % rFuncts.size());
            fn    = rFuncts[idx];
            instr = {mipsExecPkg::OP_SPECIAL, 15'($urandom), 5'($urandom), fn};
            runOne(i % 4, instr, $urandom, $urandom, $sformatf("rtype fn %h #%0d", fn, i));
        end

        // half of the immediates negative for the extension checks.
        for (int k = 0; k < 8 * iOps.size(); k++)
        begin
            imm   = {1'(k % 2), 15'($urandom)};
            instr = {iOps[k / 8], 10'($urandom), imm};
            runOne(k % 4, instr, $urandom, $urandom,
                   $sformatf("itype op %h #%0d", iOps[k / 8], k));
        end

        for (int k = 0; k < 8 * sFuncts.size(); k++)
        begin
            instr = {mipsExecPkg::OP_SPECIAL, 15'($urandom), 5'($urandom), sFuncts[k / 8]};
            runOne(k % 4, instr, $urandom, $urandom,
                   $sformatf("shift fn %h #%0d", sFuncts[k / 8], k));
        end

        runOne(1, {mipsExecPkg::OP_SPECIAL, 20'h0, mipsExecPkg::FN_ADD},
               32'h7fffffff, 32'h1, "overflow add");
        runOne(1, {mipsExecPkg::OP_SPECIAL, 20'h0, mipsExecPkg::FN_ADDU},
               32'h7fffffff, 32'h1, "overflow addu");
        runOne(1, {mipsExecPkg::OP_SPECIAL, 20'h0, mipsExecPkg::FN_SUB},
               32'h80000000, 32'h1, "overflow sub");
        runOne(1, {mipsExecPkg::OP_SPECIAL, 20'h0, mipsExecPkg::FN_SUBU},
               32'h80000000, 32'h1, "overflow subu");
        runOne(1, {mipsExecPkg::OP_ADDI, 10'h0, 16'h0001}, 32'h7fffffff, 32'h0, "overflow addi");
        runOne(1, {mipsExecPkg::OP_ADDIU, 10'h0, 16'h0001}, 32'h7fffffff, 32'h0, "overflow addiu");

        apbXfer(1'b0, laneAddr(2, mipsExecPkg::REG_RESULT), 32'h0, data, err);
        checkVal("result read not done", 32'h1, {31'b0, err});
        apbXfer(1'b1, laneAddr(0, mipsExecPkg::REG_RESULT), 32'h1234, data, err);
        checkVal("result write", 32'h1, {31'b0, err});
        apbXfer(1'b1, 8'h50, 32'h5678, data, err);
        checkVal("unmapped write", 32'h1, {31'b0, err});
        apbXfer(1'b0, 8'h80, 32'h0, data, err);
        checkVal("unmapped read", 32'h1, {31'b0, err});

        // all lanes in flight at once.
        for (int l = 0; l < mipsExecPkg::NUM_LANES; l++)
        begin
            idx = int'($urandom % rFuncts.size());
            aOps.push_back($urandom);
            bOps.push_back($urandom);
            instrs.push_back({mipsExecPkg::OP_SPECIAL, 15'($urandom), 5'($urandom), rFuncts[idx]});
            writeOk(laneAddr(l, mipsExecPkg::REG_RS), aOps[l], "parallel");
            writeOk(laneAddr(l, mipsExecPkg::REG_RT), bOps[l], "parallel");
        end
        for (int l = 0; l < mipsExecPkg::NUM_LANES; l++)
            writeOk(laneAddr(l, mipsExecPkg::REG_INSTR), instrs[l], "parallel");
        do
            readOk(mipsExecPkg::REG_STATUS, "parallel poll", data);
        while ((data & 32'hF) != 32'hF);
        for (int l = 0; l < mipsExecPkg::NUM_LANES; l++)
        begin
            readOk(laneAddr(l, mipsExecPkg::REG_RESULT), "parallel", data);
            checkVal($sformatf("parallel lane %0d", l),
                     refResult(instrs[l], aOps[l], bOps[l], trapDummy), data);
        end

        if (mipsExecTop_i.mipsExecProps_i.errCount == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Property checks failed %0d times", mipsExecTop_i.mipsExecProps_i.errCount);
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule
